//--- logic/imgproc_pkg.sv
package imgproc_pkg;

    // ------------------------------------------------------------------
    // image geometry
    // ------------------------------------------------------------------
    localparam int IMG_W   = 8;
    localparam int IMG_H   = 8;
    localparam int IMG_C   = 32;
    localparam int IMG_PIX = IMG_W * IMG_H * IMG_C;

    // address = channel*64 + y*8 + x
    localparam int ADDR_W  = 11;
    localparam int COORD_W = 3;
    localparam int CH_W    = 6;

    // datapath widths
    localparam int PIX_W = 8;
    localparam int OUT_W = 14;
    // 32 ch * weight 16 * 255 stays below 2^18
    localparam int ACC_W = 18;

    // origin saturates here so the 2x2 tile stays inside the image
    localparam logic [COORD_W-1:0] ORG_MAX = 3'd6;

    // conv rounding, (sum + 8) >> 4
    localparam logic [ACC_W-1:0] CONV_BIAS  = 18'd8;
    localparam int               CONV_SHIFT = 4;

    // ------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        OP_LOAD    = 4'd0,
        OP_ORG_R   = 4'd1,
        OP_ORG_L   = 4'd2,
        OP_ORG_U   = 4'd3,
        OP_ORG_D   = 4'd4,
        OP_SCALE_D = 4'd5,
        OP_SCALE_U = 4'd6,
        OP_DISPLAY = 4'd7,
        OP_CONV    = 4'd8
    } op_mode_t;

    typedef enum logic [1:0] {
        DEPTH_8  = 2'd0,
        DEPTH_16 = 2'd1,
        DEPTH_32 = 2'd2
    } depth_t;

    // work handed from decode to execute
    typedef enum logic [1:0] {
        CMD_LOAD    = 2'd0,
        CMD_DISPLAY = 2'd1,
        CMD_CONV    = 2'd2
    } cmd_kind_t;

    // ------------------------------------------------------------------
    // block-to-block bundles
    // ------------------------------------------------------------------
    typedef struct packed {
        cmd_kind_t            kind;
        logic [COORD_W-1:0]   origin_x;
        logic [COORD_W-1:0]   origin_y;
        logic [CH_W-1:0]      chan_cnt;
    } exec_cmd_t;

    typedef struct packed {
        logic                 en;
        logic                 we;
        logic [ADDR_W-1:0]    addr;
        logic [PIX_W-1:0]     wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 valid;
        cmd_kind_t            kind;
        logic [ACC_W-1:0]     value;
    } exec_res_t;

endpackage

//--- logic/imgproc_decode.sv
`timescale 1ns/1ps

module imgproc_decode (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_op_valid,
    input  imgproc_pkg::op_mode_t  i_op_mode,
    input  logic                   i_done,
    output logic                   o_op_ready,
    output logic                   o_start,
    output imgproc_pkg::exec_cmd_t o_cmd
);
    import imgproc_pkg::*;

    typedef enum logic [1:0] {
        S_READY,
        S_WAIT,
        S_BUSY
    } state_t;

    state_t             state;
    logic [COORD_W-1:0] org_x;
    logic [COORD_W-1:0] org_y;
    depth_t             depth;

    // opcode classification
    logic               issue;
    cmd_kind_t          issue_kind;

    // active channel count for the current depth
    function automatic logic [CH_W-1:0] depth_chans(input depth_t d);
        case (d)
            DEPTH_8:  return 6'd8;
            DEPTH_16: return 6'd16;
            default:  return 6'd32;
        endcase
    endfunction

    // only load, display and conv need the execute block
    always_comb begin
        issue      = 1'b0;
        issue_kind = CMD_LOAD;
        case (i_op_mode)
            OP_LOAD: begin
                issue      = 1'b1;
                issue_kind = CMD_LOAD;
            end
            OP_DISPLAY: begin
                issue      = 1'b1;
                issue_kind = CMD_DISPLAY;
            end
            OP_CONV: begin
                issue      = 1'b1;
                issue_kind = CMD_CONV;
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------------
    // op acceptance FSM
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= S_READY;
            o_op_ready <= 1'b0;
            o_start    <= 1'b0;
            o_cmd      <= '0;
            org_x      <= '0;
            org_y      <= '0;
            depth      <= DEPTH_32;
        end else begin
            // both strobes last one cycle
            o_op_ready <= 1'b0;
            o_start    <= 1'b0;
            case (state)
                S_READY: begin
                    o_op_ready <= 1'b1;
                    state      <= S_WAIT;
                end
                S_WAIT: begin
                    if (i_op_valid) begin
                        if (issue) begin
                            o_start        <= 1'b1;
                            o_cmd.kind     <= issue_kind;
                            o_cmd.origin_x <= org_x;
                            o_cmd.origin_y <= org_y;
                            o_cmd.chan_cnt <= depth_chans(depth);
                            state          <= S_BUSY;
                        end else begin
                            // origin, scale and unknown ops finish here
                            state <= S_READY;
                        end
                        case (i_op_mode)
                            OP_ORG_R: if (org_x < ORG_MAX) org_x <= org_x + 3'd1;
                            OP_ORG_L: if (org_x != '0) org_x <= org_x - 3'd1;
                            OP_ORG_U: if (org_y != '0) org_y <= org_y - 3'd1;
                            OP_ORG_D: if (org_y < ORG_MAX) org_y <= org_y + 3'd1;
                            OP_SCALE_D: begin
                                if (depth == DEPTH_32) depth <= DEPTH_16;
                                else if (depth == DEPTH_16) depth <= DEPTH_8;
                            end
                            OP_SCALE_U: begin
                                if (depth == DEPTH_8) depth <= DEPTH_16;
                                else if (depth == DEPTH_16) depth <= DEPTH_32;
                            end
                            default: ;
                        endcase
                    end
                end
                S_BUSY: begin
                    if (i_done) state <= S_READY;
                end
                default: state <= S_READY;
            endcase
        end
    end

endmodule

//--- logic/image_mem.sv
`timescale 1ns/1ps

module image_mem (
    input  logic                          i_clk,
    input  imgproc_pkg::mem_req_t         i_req,
    output logic [imgproc_pkg::PIX_W-1:0] o_rdata
);
    import imgproc_pkg::*;

    // ------------------------------------------------------------------
    // 2048 x 8 single-port storage
    // ------------------------------------------------------------------
    logic [PIX_W-1:0] mem [IMG_PIX];

    // write or read, one access per cycle
    // read data lands the cycle after the request
    always_ff @(posedge i_clk) begin
        if (i_req.en) begin
            if (i_req.we) begin
                mem[i_req.addr] <= i_req.wdata;
            end else begin
                o_rdata <= mem[i_req.addr];
            end
        end
    end

endmodule

//--- logic/imgproc_execute.sv
`timescale 1ns/1ps

module imgproc_execute (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_start,
    input  imgproc_pkg::exec_cmd_t        i_cmd,
    input  logic                          i_in_valid,
    input  logic [imgproc_pkg::PIX_W-1:0] i_in_data,
    output logic                          o_in_ready,
    output imgproc_pkg::mem_req_t         o_req,
    input  logic [imgproc_pkg::PIX_W-1:0] i_rdata,
    output imgproc_pkg::exec_res_t        o_res,
    output logic                          o_done
);
    import imgproc_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_RUN
    } state_t;

    state_t             state;
    exec_cmd_t          cmd_r;
    logic [ADDR_W-1:0]  load_cnt;
    // kernel x/y, channel, tile position
    logic [1:0]         kx;
    logic [1:0]         ky;
    logic [CH_W-1:0]    ch;
    logic [1:0]         pos;

    logic               is_conv;
    logic               ch_last;
    logic               win_last;
    logic               sum_first;
    logic               sum_last;
    logic               run_last;
    logic               load_last;
    logic [3:0]         tx_raw;
    logic [3:0]         ty_raw;
    logic               pad;
    logic [COORD_W-1:0] tap_x;
    logic [COORD_W-1:0] tap_y;

    // read-return stage
    logic               s1_valid;
    logic               s1_end;
    logic               s1_pad;
    logic               s1_first;
    logic               s1_last;
    logic [1:0]         s1_shift;
    logic [PIX_W-1:0]   s1_pix;
    logic [ACC_W-1:0]   weighted;
    logic [ACC_W-1:0]   acc;
    logic [ACC_W-1:0]   acc_sum;
    logic               res_end;

    // ------------------------------------------------------------------
    // tap address and padding
    // ------------------------------------------------------------------
    assign is_conv   = (cmd_r.kind == CMD_CONV);
    assign ch_last   = (ch == cmd_r.chan_cnt - 6'd1);
    assign win_last  = (kx == 2'd2) && (ky == 2'd2);
    assign sum_first = (kx == 2'd0) && (ky == 2'd0) && (ch == '0);
    assign sum_last  = win_last && ch_last;
    // display walks only the center tap
    assign run_last  = (pos == 2'd3) && ch_last && (win_last || !is_conv);
    assign load_last = i_in_valid && (load_cnt == ADDR_W'(IMG_PIX - 1));

    // coordinate plus one, so 0 means left of the image
    assign tx_raw = {1'b0, cmd_r.origin_x} + {3'b000, pos[0]} + {2'b00, kx};
    assign ty_raw = {1'b0, cmd_r.origin_y} + {3'b000, pos[1]} + {2'b00, ky};
    assign pad    = (tx_raw == 4'd0) || (tx_raw > IMG_W) ||
                    (ty_raw == 4'd0) || (ty_raw > IMG_H);
    assign tap_x  = tx_raw[2:0] - 3'd1;
    assign tap_y  = ty_raw[2:0] - 3'd1;

    assign o_in_ready = (state == S_LOAD);

    always_comb begin
        o_req = '0;
        if (state == S_LOAD) begin
            o_req.en    = i_in_valid;
            o_req.we    = 1'b1;
            o_req.addr  = load_cnt;
            o_req.wdata = i_in_data;
        end else if (state == S_RUN) begin
            // padded taps never touch the memory
            o_req.en   = !pad;
            o_req.addr = {ch[4:0], tap_y, tap_x};
        end
    end

    // ------------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= S_IDLE;
            cmd_r    <= '0;
            load_cnt <= '0;
            kx       <= '0;
            ky       <= '0;
            ch       <= '0;
            pos      <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        cmd_r    <= i_cmd;
                        load_cnt <= '0;
                        ch       <= '0;
                        pos      <= '0;
                        kx       <= (i_cmd.kind == CMD_CONV) ? 2'd0 : 2'd1;
                        ky       <= (i_cmd.kind == CMD_CONV) ? 2'd0 : 2'd1;
                        state    <= (i_cmd.kind == CMD_LOAD) ? S_LOAD : S_RUN;
                    end
                end
                S_LOAD: begin
                    if (i_in_valid) load_cnt <= load_cnt + 11'd1;
                    if (load_last) state <= S_IDLE;
                end
                S_RUN: begin
                    if (run_last) state <= S_IDLE;
                    if (!is_conv) begin
                        // display, tile position inside channel
                        pos <= pos + 2'd1;
                        if (pos == 2'd3) ch <= ch + 6'd1;
                    end else if (kx != 2'd2) begin
                        kx <= kx + 2'd1;
                    end else begin
                        kx <= 2'd0;
                        if (ky != 2'd2) begin
                            ky <= ky + 2'd1;
                        end else begin
                            ky <= 2'd0;
                            if (!ch_last) begin
                                ch <= ch + 6'd1;
                            end else begin
                                ch  <= '0;
                                pos <= pos + 2'd1;
                            end
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // read return, weighting and accumulate
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s1_valid <= 1'b0;
            s1_end   <= 1'b0;
        end else begin
            s1_valid <= (state == S_RUN);
            s1_end   <= ((state == S_RUN) && run_last) || ((state == S_LOAD) && load_last);
        end
    end

    // tags travel with the read in flight
    always_ff @(posedge i_clk) begin
        s1_pad   <= pad;
        s1_first <= sum_first;
        s1_last  <= sum_last;
        // kernel 1 2 1 / 2 4 2 / 1 2 1 as a shift count
        s1_shift <= {1'b0, kx == 2'd1} + {1'b0, ky == 2'd1};
        if (s1_valid && is_conv) acc <= acc_sum;
    end

    assign s1_pix   = s1_pad ? '0 : i_rdata;
    assign weighted = {{(ACC_W - PIX_W){1'b0}}, s1_pix} << s1_shift;
    assign acc_sum  = (s1_first ? '0 : acc) + weighted;

    // one result per display sample or finished conv sum
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_res   <= '0;
            res_end <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            o_res.valid <= s1_valid && (!is_conv || s1_last);
            o_res.kind  <= cmd_r.kind;
            o_res.value <= is_conv ? acc_sum : {{(ACC_W - PIX_W){1'b0}}, s1_pix};
            res_end     <= s1_end;
            o_done      <= res_end;
        end
    end

endmodule

//--- logic/imgproc_result.sv
`timescale 1ns/1ps

module imgproc_result (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  imgproc_pkg::exec_res_t              i_res,
    output logic                                o_out_valid,
    output logic signed [imgproc_pkg::OUT_W-1:0] o_out_data
);
    import imgproc_pkg::*;

    logic [ACC_W-1:0] rounded;
    logic [OUT_W-1:0] next_data;

    // ------------------------------------------------------------------
    // output formatting
    // ------------------------------------------------------------------
    // conv sum divided by 16, rounded half up
    assign rounded = (i_res.value + CONV_BIAS) >> CONV_SHIFT;

    // display pixels go out unsigned, zero filled
    always_comb begin
        if (i_res.kind == CMD_CONV) begin
            next_data = rounded[OUT_W-1:0];
        end else begin
            next_data = {{(OUT_W - PIX_W){1'b0}}, i_res.value[PIX_W-1:0]};
        end
    end

    // registered stream, data held between samples
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_out_valid <= 1'b0;
            o_out_data  <= '0;
        end else begin
            o_out_valid <= i_res.valid;
            if (i_res.valid) begin
                o_out_data <= signed'(next_data);
            end
        end
    end

endmodule

//--- logic/imgproc_top.sv
`timescale 1ns/1ps

module imgproc_core (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_op_valid,
    input  imgproc_pkg::op_mode_t                i_op_mode,
    input  logic                                 i_in_valid,
    input  logic [imgproc_pkg::PIX_W-1:0]        i_in_data,
    output logic                                 o_op_ready,
    output logic                                 o_in_ready,
    output logic                                 o_out_valid,
    output logic signed [imgproc_pkg::OUT_W-1:0] o_out_data
);
    import imgproc_pkg::*;

    // ------------------------------------------------------------------
    // inter-block wiring
    // ------------------------------------------------------------------
    logic             start;
    exec_cmd_t        cmd;
    logic             done;
    mem_req_t         req;
    logic [PIX_W-1:0] rdata;
    exec_res_t        res;

    // op handshake, origin and depth
    imgproc_decode u_decode (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_op_valid (i_op_valid),
        .i_op_mode  (i_op_mode),
        .i_done     (done),
        .o_op_ready (o_op_ready),
        .o_start    (start),
        .o_cmd      (cmd)
    );

    // load, display and conv sequencing
    imgproc_execute u_execute (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (start),
        .i_cmd      (cmd),
        .i_in_valid (i_in_valid),
        .i_in_data  (i_in_data),
        .o_in_ready (o_in_ready),
        .o_req      (req),
        .i_rdata    (rdata),
        .o_res      (res),
        .o_done     (done)
    );

    image_mem u_mem (
        .i_clk   (i_clk),
        .i_req   (req),
        .o_rdata (rdata)
    );

    imgproc_result u_result (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_res       (res),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data)
    );

endmodule

//--- testbench/imgproc_props.sv
`timescale 1ns/1ps

module imgproc_props (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_op_ready,
    input logic i_in_ready,
    input logic i_out_valid
);

    // ------------------------------------------------------------------
    // handshake properties
    // ------------------------------------------------------------------
    // ready is a one-cycle strobe
    a_ready_strobe: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_op_ready |=> !i_op_ready
    ) else $error("o_op_ready held high for two cycles");

    // load input and output stream never overlap
    a_in_out_apart: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(i_in_ready && i_out_valid)
    ) else $error("o_in_ready and o_out_valid high together");

    // last sample leaves before the op ends
    a_ready_after_out: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) $rose(i_op_ready) |-> !i_out_valid
    ) else $error("o_op_ready rose while o_out_valid was high");

endmodule

bind imgproc_core imgproc_props u_props (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_op_ready  (o_op_ready),
    .i_in_ready  (o_in_ready),
    .i_out_valid (o_out_valid)
);

//--- testbench/tb_imgproc.sv
`timescale 1ns/1ps

module tb_imgproc;
    import imgproc_pkg::*;

    // ------------------------------------------------------------------
    // run length budget
    // ------------------------------------------------------------------
    // load with gaps plus about 50 short ops and three conv passes at full depth
    // then doubled for margin
    localparam int MAX_CYCLES = 2 * (2 * IMG_PIX + 50 * 300 + 3 * 36 * IMG_C);

    logic                    i_clk;
    logic                    i_rst_n;
    logic                    i_op_valid;
    op_mode_t                i_op_mode;
    logic                    i_in_valid;
    logic [PIX_W-1:0]        i_in_data;
    logic                    o_op_ready;
    logic                    o_in_ready;
    logic                    o_out_valid;
    logic signed [OUT_W-1:0] o_out_data;

    // reference image and model state
    logic [PIX_W-1:0]        img [IMG_PIX];
    int                      m_ox;
    int                      m_oy;
    int                      m_chans;
    // samples seen during the last op
    logic signed [OUT_W-1:0] got [$];
    int                      sent;
    int                      cycles = 0;
    string                   test_name = "reset";

    imgproc_core i_dut (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_op_valid  (i_op_valid),
        .i_op_mode   (i_op_mode),
        .i_in_valid  (i_in_valid),
        .i_in_data   (i_in_data),
        .o_op_ready  (o_op_ready),
        .o_in_ready  (o_in_ready),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data)
    );

    // 4 ns period
    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // watchdog
    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            report_failure();
        end
    end

    // ------------------------------------------------------------------
    // failure reporting and compares
    // ------------------------------------------------------------------
    task automatic report_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compare_pixel(input logic [PIX_W-1:0] exp, input logic [PIX_W-1:0] act);
        if (exp !== act) begin
            $display("FAILED %s expected %0d actual %0d", test_name, exp, act);
            report_failure();
        end
    endtask

    task automatic compare_conv(input logic signed [OUT_W-1:0] exp,
                                input logic signed [OUT_W-1:0] act);
        if (exp !== act) begin
            $display("FAILED %s expected %0d actual %0d", test_name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_count(input int exp);
        if (got.size() != exp) begin
            $display("%s: expected %0d output samples but saw %0d",
                     test_name, exp, got.size());
            report_failure();
        end
    endtask

    // ------------------------------------------------------------------
    // image source and reference model
    // ------------------------------------------------------------------
    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic build_image();
        logic [31:0]      lfsr;
        logic [PIX_W-1:0] pix;
        lfsr = 32'h2534;
        pix  = '0;
        for (int a = 0; a < IMG_PIX; a++) begin
            // one step per bit
            for (int b = 0; b < PIX_W; b++) begin
                pix  = {pix[PIX_W-2:0], lfsr[0]};
                lfsr = lfsr_step(lfsr);
            end
            img[a] = pix;
        end
    endtask

    // origin saturates at 0 and 6 while depth halves or doubles between 8 and 32
    task automatic apply_model(input op_mode_t op);
        case (op)
            OP_ORG_R:   if (m_ox < ORG_MAX) m_ox++;
            OP_ORG_L:   if (m_ox > 0) m_ox--;
            OP_ORG_U:   if (m_oy > 0) m_oy--;
            OP_ORG_D:   if (m_oy < ORG_MAX) m_oy++;
            OP_SCALE_D: if (m_chans > 8) m_chans = m_chans / 2;
            OP_SCALE_U: if (m_chans < IMG_C) m_chans = m_chans * 2;
            default: ;
        endcase
    endtask

    function automatic logic [PIX_W-1:0] model_pixel(input int c, input int x, input int y);
        return img[c * IMG_W * IMG_H + y * IMG_W + x];
    endfunction

    // 1 2 1 / 2 4 2 / 1 2 1 around the tile pixel with zero outside
    function automatic logic signed [OUT_W-1:0] model_conv(input int px, input int py);
        int sum;
        int x;
        int y;
        int w;
        sum = 0;
        for (int c = 0; c < m_chans; c++) begin
            for (int dy = -1; dy <= 1; dy++) begin
                for (int dx = -1; dx <= 1; dx++) begin
                    x = m_ox + px + dx;
                    y = m_oy + py + dy;
                    w = (dx == 0 ? 2 : 1) * (dy == 0 ? 2 : 1);
                    if (x >= 0 && x < IMG_W && y >= 0 && y < IMG_H)
                        sum += w * model_pixel(c, x, y);
                end
            end
        end
        return OUT_W'((sum + 8) / 16);
    endfunction

    // ------------------------------------------------------------------
    // op driver and collector
    // ------------------------------------------------------------------
    task automatic wait_ready();
        do @(negedge i_clk); while (!o_op_ready);
    endtask

    // entered on the falling edge that saw o_op_ready
    task automatic run_op(input op_mode_t op);
        got.delete();
        i_op_valid = 1'b1;
        i_op_mode  = op;
        do begin
            @(negedge i_clk);
            i_op_valid = 1'b0;
            i_in_valid = 1'b0;
            if (o_out_valid) got.push_back(o_out_data);
            // load pixels with a gap now and then
            if (o_in_ready && sent < IMG_PIX && (cycles % 11) != 7) begin
                i_in_valid = 1'b1;
                i_in_data  = img[sent];
                sent++;
            end
        end while (!o_op_ready);
        apply_model(op);
    endtask

    task automatic silent_op(input op_mode_t op);
        run_op(op);
        check_count(0);
    endtask

    task automatic check_display();
        int n;
        run_op(OP_DISPLAY);
        check_count(4 * m_chans);
        n = 0;
        for (int c = 0; c < m_chans; c++) begin
            for (int p = 0; p < 4; p++) begin
                compare_pixel(model_pixel(c, m_ox + p % 2, m_oy + p / 2), got[n][PIX_W-1:0]);
                compare_pixel('0, PIX_W'(got[n] >>> PIX_W));
                n++;
            end
        end
    endtask

    task automatic check_conv();
        run_op(OP_CONV);
        check_count(4);
        for (int p = 0; p < 4; p++) begin
            compare_conv(model_conv(p % 2, p / 2), got[p]);
        end
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic test_load_display();
        test_name = "load_display";
        sent = 0;
        silent_op(OP_LOAD);
        if (sent != IMG_PIX) begin
            $display("load ended after %0d of %0d pixels", sent, IMG_PIX);
            report_failure();
        end
        check_display();
    endtask

    task automatic test_origin();
        test_name = "origin";
        repeat (7) silent_op(OP_ORG_R);
        repeat (7) silent_op(OP_ORG_D);
        check_display();
        silent_op(OP_ORG_L);
        silent_op(OP_ORG_U);
        check_display();
    endtask

    task automatic test_depth();
        test_name = "depth";
        repeat (3) silent_op(OP_SCALE_D);
        check_display();
        repeat (2) silent_op(OP_SCALE_U);
        check_display();
    endtask

    task automatic test_conv();
        test_name = "conv_corner";
        repeat (6) silent_op(OP_ORG_L);
        repeat (6) silent_op(OP_ORG_U);
        check_conv();
        // interior origin (3,2)
        test_name = "conv_depth8";
        repeat (3) silent_op(OP_ORG_R);
        repeat (2) silent_op(OP_ORG_D);
        repeat (2) silent_op(OP_SCALE_D);
        check_conv();
        test_name = "conv_depth32";
        repeat (2) silent_op(OP_SCALE_U);
        check_conv();
    endtask

    task automatic test_unknown();
        test_name = "unknown_op";
        silent_op(op_mode_t'(4'd9));
        check_display();
    endtask

    initial begin
        i_rst_n    = 1'b0;
        i_op_valid = 1'b0;
        i_op_mode  = OP_LOAD;
        i_in_valid = 1'b0;
        i_in_data  = '0;
        m_ox       = 0;
        m_oy       = 0;
        m_chans    = IMG_C;
        sent       = 0;
        build_image();
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        if (o_op_ready !== 1'b0 || o_in_ready !== 1'b0 ||
            o_out_valid !== 1'b0 || o_out_data !== '0) begin
            $display("an output was not low during reset");
            report_failure();
        end
        i_rst_n = 1'b1;
        wait_ready();
        test_load_display();
        test_origin();
        test_depth();
        test_conv();
        test_unknown();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- tb.f
logic/imgproc_pkg.sv
logic/imgproc_decode.sv
logic/image_mem.sv
logic/imgproc_execute.sv
logic/imgproc_result.sv
logic/imgproc_top.sv
testbench/imgproc_props.sv
testbench/tb_imgproc.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_imgproc
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
